/* rtl/bank_read_ctrl.sv */
/*
  Read side of the rotator. Replays the full bank (cols_1+1)*(blocks_1+1)
  times through a registered output beat, steps the nested counters on
  each accepted beat and releases the bank after the last one.
*/
`timescale 1ns/1ps
`default_nettype none

module bank_read_ctrl
  import rotator_cfg_pkg::*, rotator_stream_pkg::*;
(
  input  wire logic            i_clk,
  input  wire logic            i_reset,
  input  wire logic            i_full       [2],
  input  wire rotator_header_t i_header     [2],
  input  wire weight_word_t    i_word       [2],
  output logic                 o_rd_advance [2],
  output logic                 o_release    [2],
  output logic                 o_m_valid,
  input  wire logic            i_m_ready,
  output rotator_beat_t        o_m_beat
);

  typedef enum logic [1:0] {R_IDLE, R_LOAD, R_STREAM, R_SWITCH} r_state_t;

  r_state_t                state;
  r_state_t                state_next;
  logic                    rd_idx;
  rotator_header_t         hdr;
  rotator_beat_t           beat_next;
  logic                    m_handshake;
  logic                    step;
  logic                    at_end;
  logic [BITS_KH-1:0]      cnt_kh;
  logic [BITS_CIN-1:0]     cnt_cin;
  logic [BITS_COLS-1:0]    cnt_cols;
  logic [BITS_BLOCKS-1:0]  cnt_blocks;

  assign hdr         = i_header[rd_idx];
  assign m_handshake = o_m_valid && i_m_ready;
  // a new beat enters the output register.
  assign step   = (state == R_LOAD) ||
                  ((state == R_STREAM) && m_handshake && !o_m_beat.last);
  assign at_end = (cnt_kh == '0) && (cnt_cin == '0) &&
                  (cnt_cols == '0) && (cnt_blocks == '0);

  always_comb begin
    beat_next.data             = i_word[rd_idx];
    beat_next.user.kw_1        = hdr.kw_1;
    beat_next.user.kh_1        = hdr.kh_1;
    beat_next.user.is_1x1      = (hdr.kw_1 == '0);
    beat_next.user.is_top      = (cnt_blocks == hdr.blocks_1);
    beat_next.user.is_bottom   = (cnt_blocks == '0);
    beat_next.user.is_col_edge = (cnt_cols == BITS_COLS'(hdr.kw_1 >> 1));
    beat_next.last             = at_end;
  end

  always_comb begin
    o_rd_advance = '{default: 1'b0};
    o_release    = '{default: 1'b0};
    o_rd_advance[rd_idx] = step;
    o_release[rd_idx]    = (state == R_SWITCH);
  end

  always_comb begin
    state_next = state;
    unique case (state)
      R_IDLE:   if (i_full[rd_idx]) state_next = R_LOAD;
      R_LOAD:   state_next = R_STREAM;
      R_STREAM: if (m_handshake && o_m_beat.last) state_next = R_SWITCH;
      R_SWITCH: state_next = R_IDLE;
      default:  state_next = R_IDLE;
    endcase
  end

  // ******************************
  // control and replay counters
  // ******************************
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state      <= R_IDLE;
      rd_idx     <= 1'b0;
      o_m_valid  <= 1'b0;
      cnt_kh     <= '0;
      cnt_cin    <= '0;
      cnt_cols   <= '0;
      cnt_blocks <= '0;
    end else begin
      state <= state_next;
      if (state == R_SWITCH)
        rd_idx <= ~rd_idx;
      if (state == R_LOAD)
        o_m_valid <= 1'b1;
      else if (m_handshake && o_m_beat.last)
        o_m_valid <= 1'b0;

      if (state == R_IDLE && i_full[rd_idx]) begin
        cnt_kh     <= hdr.kh_1;
        cnt_cin    <= hdr.cin_1;
        cnt_cols   <= hdr.cols_1;
        cnt_blocks <= hdr.blocks_1;
      end else if (step) begin
        cnt_kh <= (cnt_kh == '0) ? hdr.kh_1 : cnt_kh - 1'b1;  // innermost.
        if (cnt_kh == '0) begin
          cnt_cin <= (cnt_cin == '0) ? hdr.cin_1 : cnt_cin - 1'b1;
          if (cnt_cin == '0) begin
            cnt_cols <= (cnt_cols == '0) ? hdr.cols_1 : cnt_cols - 1'b1;
            if (cnt_cols == '0)
              cnt_blocks <= (cnt_blocks == '0) ? hdr.blocks_1 : cnt_blocks - 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (step)
      o_m_beat <= beat_next;
  end

  a_beat_stable : assert property (
    @(posedge i_clk) disable iff (i_reset)
    (o_m_valid && !i_m_ready) |=> (o_m_valid && $stable(o_m_beat))
  );

endmodule

`default_nettype wire

/* rtl/bank_write_ctrl.sv */
/*
  Write side of the rotator. Waits for the write bank to empty, takes one
  header beat and then the weight words up to the last beat, marks the
  bank full and moves on to the other bank.
*/
`timescale 1ns/1ps
`default_nettype none

module bank_write_ctrl
  import rotator_cfg_pkg::*, rotator_stream_pkg::*;
(
  input  wire logic         i_clk,
  input  wire logic         i_reset,
  input  wire logic         i_s_valid,
  input  wire weight_word_t i_s_data,
  input  wire logic         i_s_last,
  output logic              o_s_ready,
  input  wire logic         i_full     [2],
  output logic              o_hdr_we   [2],
  output logic              o_word_we  [2],
  output logic              o_set_full [2],
  output rotator_header_t   o_header
);

  typedef enum logic [1:0] {W_IDLE, W_HEADER, W_WRITE, W_SWITCH} w_state_t;

  w_state_t              state;
  w_state_t              state_next;
  logic                  wr_idx;
  logic                  s_handshake;
  logic [BITS_ADDR-1:0]  word_cnt;
  logic [BITS_ADDR-1:0]  word_last_q;

  assign o_s_ready   = (state == W_HEADER) || (state == W_WRITE);
  assign s_handshake = i_s_valid && o_s_ready;
  assign o_header    = rotator_header_t'(i_s_data[HEADER_BITS-1:0]);

  // ******************************
  // strobes to the write bank
  // ******************************
  always_comb begin
    o_hdr_we   = '{default: 1'b0};
    o_word_we  = '{default: 1'b0};
    o_set_full = '{default: 1'b0};
    o_hdr_we[wr_idx]   = (state == W_HEADER) && s_handshake;
    o_word_we[wr_idx]  = (state == W_WRITE) && s_handshake;
    o_set_full[wr_idx] = (state == W_WRITE) && s_handshake && i_s_last;
  end

  always_comb begin
    state_next = state;
    unique case (state)
      W_IDLE:   if (!i_full[wr_idx]) state_next = W_HEADER;
      W_HEADER: if (s_handshake) state_next = W_WRITE;
      W_WRITE:  if (s_handshake && i_s_last) state_next = W_SWITCH;
      W_SWITCH: state_next = W_IDLE;
      default:  state_next = W_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state  <= W_IDLE;
      wr_idx <= 1'b0;
    end else begin
      state <= state_next;
      if (state == W_SWITCH)
        wr_idx <= ~wr_idx;  // other bank next.
    end
  end

  // word position within the set.
  always_ff @(posedge i_clk) begin
    if (state == W_HEADER && s_handshake) begin
      word_cnt    <= '0;
      word_last_q <= word_last(o_header);
    end else if (state == W_WRITE && s_handshake) begin
      word_cnt <= word_cnt + 1'b1;
    end
  end

  a_last_on_count : assert property (
    @(posedge i_clk) disable iff (i_reset)
    (state == W_WRITE && s_handshake) |-> (i_s_last == (word_cnt == word_last_q))
  );

endmodule

`default_nettype wire

/* rtl/rotator_cfg_pkg.sv */
/*
  Sizing of the weight rotator. The kernel, channel and image limits
  set the stream width, the bank depth and every counter width.
*/
`default_nettype none

package rotator_cfg_pkg;

  localparam int WORD_WIDTH = 8;
  localparam int CORES      = 2;
  localparam int KW_MAX     = 3;   // odd kernels only.
  localparam int KH_MAX     = 3;
  localparam int CIN_MAX    = 64;
  localparam int COLS_MAX   = 32;
  localparam int BLOCKS_MAX = 8;

  // one beat holds a full kernel row for every core.
  localparam int BEAT_BITS  = WORD_WIDTH * CORES * KW_MAX;
  localparam int BANK_DEPTH = KH_MAX * CIN_MAX;

  localparam int BITS_KW     = $clog2(KW_MAX);
  localparam int BITS_KH     = $clog2(KH_MAX);
  localparam int BITS_CIN    = $clog2(CIN_MAX);
  localparam int BITS_COLS   = $clog2(COLS_MAX);
  localparam int BITS_BLOCKS = $clog2(BLOCKS_MAX);
  localparam int BITS_ADDR   = $clog2(BANK_DEPTH);

endpackage

`default_nettype wire

/* rtl/rotator_stream_pkg.sv */
/*
  Beat formats of the rotator streams: the header of a weight set, the
  user flags sent with each output beat and the output beat itself.
*/
`default_nettype none

package rotator_stream_pkg;

  import rotator_cfg_pkg::*;

  // all fields hold value minus one.
  typedef struct packed {
    logic [BITS_BLOCKS-1:0] blocks_1;
    logic [BITS_COLS-1:0]   cols_1;
    logic [BITS_CIN-1:0]    cin_1;
    logic [BITS_KH-1:0]     kh_1;
    logic [BITS_KW-1:0]     kw_1;
  } rotator_header_t;

  localparam int HEADER_BITS = $bits(rotator_header_t);

  typedef struct packed {
    logic [BITS_KW-1:0] kw_1;
    logic [BITS_KH-1:0] kh_1;
    logic               is_1x1;
    logic               is_top;       // first block.
    logic               is_bottom;    // last block.
    logic               is_col_edge;
  } rotator_user_t;

  typedef logic [BEAT_BITS-1:0] weight_word_t;

  typedef struct packed {
    weight_word_t  data;
    rotator_user_t user;
    logic          last;
  } rotator_beat_t;

  // last stored word sits at (kh_1+1)*(cin_1+1)-1.
  function automatic logic [BITS_ADDR-1:0] word_last(rotator_header_t hdr);
    return BITS_ADDR'(hdr.kh_1) * BITS_ADDR'(hdr.cin_1) +
           BITS_ADDR'(hdr.kh_1) + BITS_ADDR'(hdr.cin_1);
  endfunction

endpackage

`default_nettype wire

/* rtl/weight_bank.sv */
/*
  One ping-pong bank. Words are written in order behind a latched header,
  then read back cyclically. The read port is registered and prefetched,
  so o_word always holds the word at the read pointer.
*/
`timescale 1ns/1ps
`default_nettype none

module weight_bank
  import rotator_cfg_pkg::*, rotator_stream_pkg::*;
(
  input  wire logic            i_clk,
  input  wire logic            i_reset,
  input  wire logic            i_hdr_we,
  input  wire rotator_header_t i_header,
  input  wire logic            i_word_we,
  input  wire weight_word_t    i_word,
  input  wire logic            i_set_full,
  input  wire logic            i_rd_advance,
  input  wire logic            i_release,
  output logic                 o_full,
  output rotator_header_t      o_header,
  output weight_word_t         o_word
);

  weight_word_t           mem [BANK_DEPTH];
  logic [BITS_ADDR-1:0]   wr_ptr;
  logic [BITS_ADDR-1:0]   rd_ptr;
  logic [BITS_ADDR-1:0]   rd_ptr_next;
  logic [BITS_ADDR-1:0]   rd_last;

  assign rd_last = word_last(o_header);

  always_comb begin
    rd_ptr_next = rd_ptr;
    if (i_release) begin
      rd_ptr_next = '0;
    end else if (i_rd_advance) begin
      rd_ptr_next = (rd_ptr == rd_last) ? '0 : rd_ptr + 1'b1;  // wrap to first word.
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_full <= 1'b0;
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      rd_ptr <= rd_ptr_next;
      if (i_release) begin
        o_full <= 1'b0;
        wr_ptr <= '0;
      end else begin
        if (i_set_full)
          o_full <= 1'b1;
        if (i_hdr_we)
          wr_ptr <= '0;
        else if (i_word_we)
          wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_hdr_we)
      o_header <= i_header;
  end

  // read before write at the next pointer.
  always_ff @(posedge i_clk) begin
    if (i_word_we)
      mem[wr_ptr] <= i_word;
    o_word <= mem[rd_ptr_next];
  end

  a_no_write_when_full : assert property (
    @(posedge i_clk) disable iff (i_reset) i_word_we |-> !o_full
  );

endmodule

`default_nettype wire

/* rtl/weight_rotator.sv */
/*
  Top of the weight rotator. Two banks in ping-pong: the write controller
  fills one while the read controller replays the other.
*/
`timescale 1ns/1ps
`default_nettype none

module weight_rotator
  import rotator_stream_pkg::*;
(
  input  wire logic         i_clk,
  input  wire logic         i_reset,
  input  wire logic         i_s_valid,
  output logic              o_s_ready,
  input  wire weight_word_t i_s_data,
  input  wire logic         i_s_last,
  output logic              o_m_valid,
  input  wire logic         i_m_ready,
  output rotator_beat_t     o_m_beat
);

  logic             bank_full    [2];
  logic             hdr_we       [2];
  logic             word_we      [2];
  logic             set_full     [2];
  logic             rd_advance   [2];
  logic             bank_release [2];
  rotator_header_t  bank_header  [2];
  weight_word_t     bank_word    [2];
  rotator_header_t  wr_header;

  bank_write_ctrl u_write (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_s_valid  (i_s_valid),
    .i_s_data   (i_s_data),
    .i_s_last   (i_s_last),
    .o_s_ready  (o_s_ready),
    .i_full     (bank_full),
    .o_hdr_we   (hdr_we),
    .o_word_we  (word_we),
    .o_set_full (set_full),
    .o_header   (wr_header)
  );

  for (genvar b = 0; b < 2; b++) begin : g_bank
    weight_bank u_bank (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_hdr_we     (hdr_we[b]),
      .i_header     (wr_header),
      .i_word_we    (word_we[b]),
      .i_word       (i_s_data),      // shared word bus.
      .i_set_full   (set_full[b]),
      .i_rd_advance (rd_advance[b]),
      .i_release    (bank_release[b]),
      .o_full       (bank_full[b]),
      .o_header     (bank_header[b]),
      .o_word       (bank_word[b])
    );
  end

  bank_read_ctrl u_read (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_full       (bank_full),
    .i_header     (bank_header),
    .i_word       (bank_word),
    .o_rd_advance (rd_advance),
    .o_release    (bank_release),
    .o_m_valid    (o_m_valid),
    .i_m_ready    (i_m_ready),
    .o_m_beat     (o_m_beat)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the weight rotator testbench with Verilator and runs it.
verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module weight_rotator_tb -o weight_rotator_sim &&
  ./obj_dir/weight_rotator_sim | tee /dev/stderr | grep -q "^Regression passed$" &&
  echo "simulation status: ok" ||
  { echo "simulation status: failing"; exit 1; }

/* src.f */
rtl/rotator_cfg_pkg.sv
rtl/rotator_stream_pkg.sv
rtl/weight_bank.sv
rtl/bank_write_ctrl.sv
rtl/bank_read_ctrl.sv
rtl/weight_rotator.sv
test/weight_rotator_tb.sv

/* test/weight_rotator_tb.sv */
/*
  Testbench for the weight rotator. Random weight sets enter on the input
  stream, a queue model predicts every output beat, and a sink process
  compares the beats under optional random back-pressure.
*/
`timescale 1ns/1ps
`default_nettype none

module weight_rotator_tb import rotator_cfg_pkg::*, rotator_stream_pkg::*;;

  localparam int TIMEOUT = 10000;

  logic           i_clk = 1'b0;
  logic           i_reset;
  logic           i_s_valid;
  logic           o_s_ready;
  weight_word_t   i_s_data;
  logic           i_s_last;
  logic           o_m_valid;
  logic           i_m_ready = 1'b0;
  rotator_beat_t  o_m_beat;

  int             seed = 32'h8bf6_2f9a;
  logic           ready_pat [512];
  logic           bp_on = 1'b0;
  int             cyc = 0;
  int             errors = 0;
  int             valid_count = 0;
  int             out_count = 0;
  int             last_count = 0;
  int             test_num = 0;
  weight_word_t   src_data [$];
  logic           src_last [$];
  weight_word_t   exp_data [$];
  rotator_user_t  exp_user [$];
  logic           exp_last [$];

  weight_rotator i_dut (.*);

  always #5 i_clk = ~i_clk;

  task automatic check_word(input string name, input weight_word_t got, input weight_word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_user(input string name, input rotator_user_t got, input rotator_user_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_last(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Regression failed");
    $finish;
  endtask

  task automatic report_test(input string name, input int err_before);
    test_num++;
    $display("test %0d %-20s %0d errors", test_num, name, errors - err_before);
  endtask

  // odd kernels only and small sets for a short replay.
  function automatic rotator_header_t random_header();
    rotator_header_t h;
    h = '0;
    h.kw_1     = ($random(seed) & 1) ? 2'd2 : 2'd0;
    h.kh_1     = BITS_KH'($unsigned($random(seed)) % 3);
    h.cin_1    = BITS_CIN'($unsigned($random(seed)) % 6);
    h.cols_1   = BITS_COLS'($unsigned($random(seed)) % 4);
    h.blocks_1 = BITS_BLOCKS'($unsigned($random(seed)) % 3);
    return h;
  endfunction

  // ******************************
  // model of one weight set
  // ******************************
  task automatic make_set(input rotator_header_t hdr, output int n_in, output int n_out);
    weight_word_t   words [$];
    weight_word_t   w;
    rotator_user_t  u;
    int             n_words;
    n_words = (int'(hdr.kh_1) + 1) * (int'(hdr.cin_1) + 1);
    n_in    = n_words + 1;
    n_out   = n_words * (int'(hdr.cols_1) + 1) * (int'(hdr.blocks_1) + 1);
    w = weight_word_t'({$random(seed), $random(seed)});
    w[HEADER_BITS-1:0] = hdr;  // upper bits are noise.
    src_data.push_back(w);
    src_last.push_back(1'b0);
    for (int k = 0; k < n_words; k++) begin
      w = weight_word_t'({$random(seed), $random(seed)});
      words.push_back(w);
      src_data.push_back(w);
      src_last.push_back(k == n_words - 1);
    end
    for (int b = 0; b <= int'(hdr.blocks_1); b++) begin
      for (int c = 0; c <= int'(hdr.cols_1); c++) begin
        for (int k = 0; k < n_words; k++) begin
          u.kw_1        = hdr.kw_1;
          u.kh_1        = hdr.kh_1;
          u.is_1x1      = (hdr.kw_1 == '0);
          u.is_top      = (b == 0);
          u.is_bottom   = (b == int'(hdr.blocks_1));
          u.is_col_edge = ((int'(hdr.cols_1) - c) == int'(hdr.kw_1) / 2);  // columns left.
          exp_data.push_back(words[k]);
          exp_user.push_back(u);
          exp_last.push_back((b == int'(hdr.blocks_1)) && (c == int'(hdr.cols_1)) &&
                             (k == n_words - 1));
        end
      end
    end
  endtask

  task automatic send_beats(input int n);
    int waited;
    for (int i = 0; i < n; i++) begin
      @(negedge i_clk);
      if (($random(seed) & 3) == 0) begin
        i_s_valid = 1'b0;  // idle gap.
        @(negedge i_clk);
      end
      i_s_valid = 1'b1;
      i_s_data  = src_data.pop_front();
      i_s_last  = src_last.pop_front();
      waited = 0;
      while (!o_s_ready) begin
        @(negedge i_clk);
        waited++;
        if (waited > TIMEOUT)
          report_timeout("o_s_ready");
      end
    end
    @(negedge i_clk);
    i_s_valid = 1'b0;
    i_s_last  = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(posedge i_clk);
    while (exp_data.size() != 0) begin
      @(posedge i_clk);
      waited++;
      if (waited > TIMEOUT)
        report_timeout("the output stream to drain");
    end
    repeat (20) @(posedge i_clk);  // catches stray beats.
  endtask

  // sink sets ready and judges the beat at the falling edge.
  always @(negedge i_clk) begin
    i_m_ready = bp_on ? ready_pat[cyc % 512] : 1'b1;
    cyc++;
    if (o_m_valid)
      valid_count++;
    if (o_m_valid && i_m_ready) begin
      if (exp_data.size() == 0) begin
        $display("output beat arrived with no expected beat left in the model");
        errors++;
      end else begin
        check_word("o_m_beat.data", o_m_beat.data, exp_data.pop_front());
        check_user("o_m_beat.user", o_m_beat.user, exp_user.pop_front());
        check_last("o_m_beat.last", o_m_beat.last, exp_last.pop_front());
        out_count++;
        if (o_m_beat.last)
          last_count++;
      end
    end
  end

  // ******************************
  // test sequence
  // ******************************
  initial begin
    rotator_header_t hdr;
    int              n_in [3];
    int              n_out [3];
    int              err_before;
    int              base;
    i_reset   = 1'b1;
    i_s_valid = 1'b0;
    i_s_data  = '0;
    i_s_last  = 1'b0;
    for (int i = 0; i < 512; i++)
      ready_pat[i] = ($random(seed) % 3) != 0;
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_reset = 1'b0;

    err_before = errors;
    check_last("o_m_valid", o_m_valid, 1'b0);
    check_last("o_s_ready", o_s_ready, 1'b0);
    make_set(random_header(), n_in[0], n_out[0]);
    send_beats(1);  // header only.
    repeat (40) @(posedge i_clk);
    if (valid_count != 0) begin
      $display("output became valid before any weight set was stored");
      errors++;
    end
    report_test("reset and idle", err_before);

    err_before = errors;
    base = out_count;
    send_beats(n_in[0] - 1);
    wait_drain();
    if (out_count - base != n_out[0]) begin
      $display("[FAIL] beat count got %h expected %h", out_count - base, n_out[0]);
      errors++;
    end
    report_test("replay order", err_before);

    err_before = errors;
    hdr = random_header();
    hdr.kw_1     = 2'd2;
    hdr.cols_1   = 3;
    hdr.blocks_1 = 2;
    make_set(hdr, n_in[0], n_out[0]);
    send_beats(n_in[0]);
    wait_drain();
    report_test("user flags", err_before);

    err_before = errors;
    base = last_count;
    hdr = random_header();
    hdr.kw_1 = 2'd0;
    make_set(hdr, n_in[0], n_out[0]);
    send_beats(n_in[0]);
    wait_drain();
    if (last_count - base != 1) begin
      $display("[FAIL] last beat count got %h expected %h", last_count - base, 1);
      errors++;
    end
    report_test("last flag", err_before);

    err_before = errors;
    bp_on = 1'b1;
    make_set(random_header(), n_in[0], n_out[0]);
    make_set(random_header(), n_in[1], n_out[1]);
    send_beats(n_in[0] + n_in[1]);
    wait_drain();
    report_test("back-pressure", err_before);

    err_before = errors;
    hdr = random_header();
    hdr.cin_1    = 5;
    hdr.cols_1   = 7;
    hdr.blocks_1 = 3;
    make_set(hdr, n_in[0], n_out[0]);
    make_set(random_header(), n_in[1], n_out[1]);
    make_set(random_header(), n_in[2], n_out[2]);
    base = out_count;
    send_beats(n_in[0]);
    send_beats(n_in[1]);
    @(posedge i_clk);
    if (out_count - base >= n_out[0]) begin
      $display("second set was not taken in while the first set replayed");
      errors++;
    end
    send_beats(n_in[2]);
    wait_drain();
    report_test("ping-pong overlap", err_before);

    $display("tests %0d, beats checked %0d, errors %0d", test_num, out_count, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire
